//--- rtl/code_lock_pkg.sv
`default_nettype none

package code_lock_pkg;

    // digits keep their own value so a code nibble is the key code itself
    typedef enum logic [3:0] {
        KEY_0      = 4'd0,
        KEY_1      = 4'd1,
        KEY_2      = 4'd2,
        KEY_3      = 4'd3,
        KEY_4      = 4'd4,
        KEY_5      = 4'd5,
        KEY_6      = 4'd6,
        KEY_7      = 4'd7,
        KEY_8      = 4'd8,
        KEY_9      = 4'd9,
        KEY_ENTER  = 4'd10,
        KEY_CANCEL = 4'd11,
        KEY_RESET  = 4'd12,
        KEY_NONE   = 4'd15
    } key_code_e;

    typedef struct packed {
        logic      valid;
        key_code_e code;
    } key_evt_t;

    typedef enum logic [1:0] {
        TONE_CLICK = 2'd0,
        TONE_PASS  = 2'd1,
        TONE_FAIL  = 2'd2
    } tone_e;

    typedef struct packed {
        logic  valid;
        tone_e kind;
    } tone_req_t;

    typedef enum logic [1:0] {
        ST_ENTRY  = 2'd0,
        ST_OPEN   = 2'd1,
        ST_LOCKED = 2'd2
    } lock_state_e;

    localparam int          DIGITS       = 3;
    localparam logic [3:0]  BLANK_NIBBLE = 4'hF;
    localparam logic [11:0] PASS_GLYPH   = 12'hBCC; // reads "ASS" on the display

endpackage

`default_nettype wire

//--- rtl/key_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module key_decoder (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic [15:0]             keys,
    output code_lock_pkg::key_evt_t      key_evt
);

    code_lock_pkg::key_code_e decoded;
    code_lock_pkg::key_code_e last_code; // code seen at the previous edge

    // keypad wiring is not in digit order
    always_comb begin
        case (keys)
            16'h0008: decoded = code_lock_pkg::KEY_0;
            16'h0080: decoded = code_lock_pkg::KEY_1;
            16'h0040: decoded = code_lock_pkg::KEY_2;
            16'h0020: decoded = code_lock_pkg::KEY_3;
            16'h0800: decoded = code_lock_pkg::KEY_4;
            16'h0400: decoded = code_lock_pkg::KEY_5;
            16'h0200: decoded = code_lock_pkg::KEY_6;
            16'h8000: decoded = code_lock_pkg::KEY_7;
            16'h4000: decoded = code_lock_pkg::KEY_8;
            16'h2000: decoded = code_lock_pkg::KEY_9;
            16'h0001: decoded = code_lock_pkg::KEY_ENTER;
            16'h1000: decoded = code_lock_pkg::KEY_CANCEL;
            16'h0100: decoded = code_lock_pkg::KEY_RESET;
            default:  decoded = code_lock_pkg::KEY_NONE; // idle or several keys
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_code     <= code_lock_pkg::KEY_NONE;
            key_evt.valid <= 1'b0;
        end else begin
            last_code     <= decoded;
            // new press only; a held key matches last_code
            key_evt.valid <= (decoded != code_lock_pkg::KEY_NONE) && (decoded != last_code);
            key_evt.code  <= decoded;
        end
    end

endmodule

`default_nettype wire

//--- rtl/entry_controller.sv
`timescale 1ns/100ps
`default_nettype none

module entry_controller #(
    parameter logic [11:0] SECRET_CODE = 12'h246,
    parameter int          MAX_TRIES   = 4
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire code_lock_pkg::key_evt_t     key_evt,
    input  wire logic                        lock_done,
    input  wire logic [7:0]                  seconds_bcd,
    output logic [11:0]                      display,
    output logic [2:0]                       tries,
    output code_lock_pkg::lock_state_e       state,
    output logic                             lock_start,
    output code_lock_pkg::tone_req_t         tone_req
);

    localparam int          ENTRY_W     = 4 * code_lock_pkg::DIGITS;
    localparam int          CNT_W       = $clog2(code_lock_pkg::DIGITS + 1);
    localparam logic [11:0] BLANK_ENTRY = {code_lock_pkg::DIGITS{code_lock_pkg::BLANK_NIBBLE}};

    logic [ENTRY_W-1:0] entry;   // entered digits, newest at the right
    logic [CNT_W-1:0]   count;   // digits entered so far
    logic               full;
    logic               last_try;

    assign full     = (count == CNT_W'(code_lock_pkg::DIGITS));
    assign last_try = (tries == 3'(MAX_TRIES - 1));

    always_comb begin
        case (state)
            code_lock_pkg::ST_OPEN:   display = code_lock_pkg::PASS_GLYPH;
            code_lock_pkg::ST_LOCKED: display = {4'h0, seconds_bcd}; // lockout seconds
            default:                  display = entry;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= code_lock_pkg::ST_ENTRY;
            entry          <= BLANK_ENTRY;
            count          <= '0;
            tries          <= '0;
            lock_start     <= 1'b0;
            tone_req.valid <= 1'b0;
        end else begin
            lock_start     <= 1'b0; // pulses
            tone_req.valid <= 1'b0;
            if (state == code_lock_pkg::ST_LOCKED) begin
                // keys are ignored until the timer runs out
                if (lock_done) begin
                    state <= code_lock_pkg::ST_ENTRY;
                    entry <= BLANK_ENTRY;
                    count <= '0;
                end
            end else if (key_evt.valid) begin
                case (key_evt.code)
                    code_lock_pkg::KEY_CANCEL: begin
                        state <= code_lock_pkg::ST_ENTRY;
                        entry <= BLANK_ENTRY;
                        count <= '0;
                    end
                    code_lock_pkg::KEY_RESET: begin
                        state <= code_lock_pkg::ST_ENTRY;
                        entry <= BLANK_ENTRY;
                        count <= '0;
                        tries <= '0;
                    end
                    code_lock_pkg::KEY_ENTER: begin
                        if (state == code_lock_pkg::ST_ENTRY && full) begin
                            tone_req.valid <= 1'b1;
                            if (entry == SECRET_CODE) begin
                                state         <= code_lock_pkg::ST_OPEN;
                                tone_req.kind <= code_lock_pkg::TONE_PASS;
                            end else begin
                                entry         <= BLANK_ENTRY;
                                count         <= '0;
                                tone_req.kind <= code_lock_pkg::TONE_FAIL;
                                if (last_try) begin
                                    tries      <= '0;
                                    lock_start <= 1'b1;
                                    state      <= code_lock_pkg::ST_LOCKED;
                                end else begin
                                    tries <= tries + 3'd1;
                                end
                            end
                        end
                    end
                    code_lock_pkg::KEY_NONE: begin
                        // decoder never flags this one
                    end
                    default: begin
                        // digit keys
                        if (state == code_lock_pkg::ST_ENTRY) begin
                            tone_req.valid <= 1'b1;
                            tone_req.kind  <= code_lock_pkg::TONE_CLICK;
                            if (!full) begin
                                entry <= {entry[ENTRY_W-5:0], 4'(key_evt.code)};
                                count <= count + CNT_W'(1);
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/lockout_timer.sv
`timescale 1ns/100ps
`default_nettype none

module lockout_timer #(
    parameter int TICK_DIV     = 50_000_000,
    parameter int LOCK_SECONDS = 20
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       lock_start,
    output logic [7:0]      seconds_bcd,
    output logic            lock_done
);

    localparam int         PRE_W    = $clog2(TICK_DIV + 1);
    localparam logic [7:0] LOCK_BCD = {4'(LOCK_SECONDS / 10), 4'(LOCK_SECONDS % 10)};

    logic             running;
    logic [PRE_W-1:0] prescale;   // cycles within the current second
    logic             tick;

    assign tick = (prescale == PRE_W'(TICK_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running     <= 1'b0;
            prescale    <= '0;
            seconds_bcd <= '0;
            lock_done   <= 1'b0;
        end else begin
            lock_done <= 1'b0;
            if (lock_start) begin
                running     <= 1'b1;
                prescale    <= '0;
                seconds_bcd <= '0;
            end else if (running) begin
                if (seconds_bcd == LOCK_BCD) begin
                    running     <= 1'b0; // back to idle at zero
                    seconds_bcd <= '0;
                    lock_done   <= 1'b1;
                end else if (tick) begin
                    prescale <= '0;
                    if (seconds_bcd[3:0] == 4'd9) begin
                        seconds_bcd[3:0] <= 4'd0;
                        seconds_bcd[7:4] <= seconds_bcd[7:4] + 4'd1; // carry to tens
                    end else begin
                        seconds_bcd[3:0] <= seconds_bcd[3:0] + 4'd1;
                    end
                end else begin
                    prescale <= prescale + PRE_W'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/tone_generator.sv
`timescale 1ns/100ps
`default_nettype none

module tone_generator #(
    parameter int HALF_PERIOD = 50_000,
    parameter int BEEP_LEN    = 10_000_000
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire code_lock_pkg::tone_req_t tone_req,
    output logic                          buzzer
);

    localparam int PASS_HALF = (HALF_PERIOD > 1) ? HALF_PERIOD / 2 : 1;
    localparam int FAIL_HALF = 2 * HALF_PERIOD;
    localparam int LONG_LEN  = 3 * BEEP_LEN;
    localparam int HALF_W    = $clog2(FAIL_HALF + 1);
    localparam int DUR_W     = $clog2(LONG_LEN + 1);

    code_lock_pkg::tone_e kind;
    logic                 active;
    logic                 level;     // square wave before muting
    logic [DUR_W-1:0]     dur_cnt;   // cycles since the request
    logic [HALF_W-1:0]    half_cnt;
    logic [HALF_W-1:0]    half_len;
    logic [DUR_W-1:0]     tone_len;
    logic                 mute;

    always_comb begin
        case (kind)
            code_lock_pkg::TONE_PASS: begin
                half_len = HALF_W'(PASS_HALF); // fast
                tone_len = DUR_W'(LONG_LEN);
            end
            code_lock_pkg::TONE_FAIL: begin
                half_len = HALF_W'(FAIL_HALF); // slow
                tone_len = DUR_W'(LONG_LEN);
            end
            default: begin
                half_len = HALF_W'(HALF_PERIOD);
                tone_len = DUR_W'(BEEP_LEN);
            end
        endcase
    end

    // fail tone is silent for its middle third
    assign mute = (kind == code_lock_pkg::TONE_FAIL)
                  && (dur_cnt >= DUR_W'(BEEP_LEN))
                  && (dur_cnt < DUR_W'(2 * BEEP_LEN));

    assign buzzer = active && level && !mute;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kind     <= code_lock_pkg::TONE_CLICK;
            active   <= 1'b0;
            level    <= 1'b0;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (tone_req.valid) begin
            // restart, even over a tone still playing
            kind     <= tone_req.kind;
            active   <= 1'b1;
            level    <= 1'b1;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (active) begin
            if (half_cnt == half_len - HALF_W'(1)) begin
                half_cnt <= '0;
                level    <= ~level;
            end else begin
                half_cnt <= half_cnt + HALF_W'(1);
            end
            if (dur_cnt == tone_len - DUR_W'(1)) begin
                active <= 1'b0; // tone over, stay quiet
                level  <= 1'b0;
            end else begin
                dur_cnt <= dur_cnt + DUR_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/code_lock_top.sv
`timescale 1ns/100ps
`default_nettype none

module code_lock_top #(
    parameter logic [11:0] SECRET_CODE  = 12'h246,
    parameter int          MAX_TRIES    = 4,          // 1 to 7
    parameter int          TICK_DIV     = 50_000_000, // clock cycles per second
    parameter int          LOCK_SECONDS = 20,
    parameter int          HALF_PERIOD  = 50_000,
    parameter int          BEEP_LEN     = 10_000_000
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [15:0] keys,
    output logic [11:0]      display,
    output logic [2:0]       tries,
    output logic             locked,
    output logic             open,
    output logic             buzzer
);

    code_lock_pkg::key_evt_t    key_evt;
    code_lock_pkg::tone_req_t   tone_req;
    code_lock_pkg::lock_state_e state;
    logic                       lock_start;
    logic                       lock_done;
    logic [7:0]                 seconds_bcd;

    key_decoder u_key_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .keys    (keys),
        .key_evt (key_evt)
    );

    entry_controller #(
        .SECRET_CODE (SECRET_CODE),
        .MAX_TRIES   (MAX_TRIES)
    ) u_entry_controller (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_evt     (key_evt),
        .lock_done   (lock_done),
        .seconds_bcd (seconds_bcd),
        .display     (display),
        .tries       (tries),
        .state       (state),
        .lock_start  (lock_start),
        .tone_req    (tone_req)
    );

    lockout_timer #(
        .TICK_DIV     (TICK_DIV),
        .LOCK_SECONDS (LOCK_SECONDS)
    ) u_lockout_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .lock_start  (lock_start),
        .seconds_bcd (seconds_bcd),
        .lock_done   (lock_done)
    );

    tone_generator #(
        .HALF_PERIOD (HALF_PERIOD),
        .BEEP_LEN    (BEEP_LEN)
    ) u_tone_generator (
        .clk      (clk),
        .rst_n    (rst_n),
        .tone_req (tone_req),
        .buzzer   (buzzer)
    );

    assign locked = (state == code_lock_pkg::ST_LOCKED);
    assign open   = (state == code_lock_pkg::ST_OPEN);

endmodule

`default_nettype wire

//--- testbench/tb_code_lock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_code_lock;

    localparam int TICK_DIV     = 20;
    localparam int LOCK_SECONDS = 3;
    localparam int HALF_PERIOD  = 2;
    localparam int BEEP_LEN     = 12;
    localparam int MAX_TRIES    = 4;
    localparam int ROW_WORDS    = 8;    // words per data file row
    localparam int MAX_ROWS     = 64;
    localparam int TONE_START   = 3;    // edges from key press to buzzer high
    localparam int TONE_CYCLES  = TONE_START + 3 * BEEP_LEN + 2;

    logic        clk;
    logic        rst_n;
    logic [15:0] keys;
    logic [11:0] display;
    logic [2:0]  tries;
    logic        locked;
    logic        open;
    logic        buzzer;
    logic [31:0] rows [0:ROW_WORDS*MAX_ROWS-1];
    int          errors;
    int          checks;

    code_lock_top #(
        .SECRET_CODE  (12'h246),
        .MAX_TRIES    (MAX_TRIES),
        .TICK_DIV     (TICK_DIV),
        .LOCK_SECONDS (LOCK_SECONDS),
        .HALF_PERIOD  (HALF_PERIOD),
        .BEEP_LEN     (BEEP_LEN)
    ) u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .keys    (keys),
        .display (display),
        .tries   (tries),
        .locked  (locked),
        .open    (open),
        .buzzer  (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [11:0] got,
                               input logic [11:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_outputs(input logic [11:0] exp_display, input logic [2:0] exp_tries,
                                 input logic exp_locked, input logic exp_open);
        check_value("display", display, exp_display);
        check_value("tries", 12'(tries), 12'(exp_tries));
        check_value("locked", 12'(locked), 12'(exp_locked));
        check_value("open", 12'(open), 12'(exp_open));
    endtask

    // press for hold cycles then release; tone 1 click, 2 pass, 3 fail
    task automatic press_key(input logic [15:0] pattern, input int hold, input int tone);
        int   cycles;
        int   toggles;
        logic prev_buzz;
        cycles    = (tone != 0) ? TONE_CYCLES : 2 * hold;
        if (cycles < 2 * hold)
            cycles = 2 * hold;
        toggles   = 0;
        prev_buzz = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            keys <= (i < hold) ? pattern : 16'h0000;
            @(negedge clk);
            if (tone != 0) begin
                if (i == TONE_START)
                    check_value("buzzer", 12'(buzzer), 12'h001);
                if (i > TONE_START && i < TONE_START + BEEP_LEN && buzzer != prev_buzz)
                    toggles++;
                if (tone == 3 && i >= TONE_START + BEEP_LEN && i < TONE_START + 2 * BEEP_LEN)
                    check_value("buzzer", 12'(buzzer), 12'h000); // muted middle third
                if (i >= TONE_START + 3 * BEEP_LEN)
                    check_value("buzzer", 12'(buzzer), 12'h000); // tone over
            end
            prev_buzz = buzzer;
        end
        if (tone != 0) begin
            assert (toggles > 0) else begin
                errors++;
                $display("buzzer never toggled in the first beep of the tone at %0t", $time);
            end
        end
    endtask

    // follow the seconds count until the lock drops back to entry
    task automatic wait_lockout();
        logic [11:0] prev;
        logic [11:0] want;
        int          waited;
        for (int s = 1; s <= LOCK_SECONDS; s++) begin
            prev   = display;
            want   = {4'h0, 4'(s / 10), 4'(s % 10)};
            waited = 0;
            while (display == prev && waited < 2 * TICK_DIV) begin
                @(negedge clk);
                waited++;
            end
            if (waited >= 2 * TICK_DIV) begin
                errors++;
                $display("display did not change within %0d cycles during lockout", waited);
            end
            check_value("display", display, want);
        end
        waited = 0;
        while (locked && waited < 2 * TICK_DIV) begin
            @(negedge clk);
            waited++;
        end
        assert (!locked) else begin
            errors++;
            $display("lock stayed in lockout after the last second at %0t", $time);
        end
    endtask

    initial begin
        int op;
        int base;
        errors = 0;
        checks = 0;
        keys  <= 16'h0000;
        rst_n <= 1'b0;
        $readmemh("testbench/code_lock_testdata.txt", rows);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs(12'hFFF, 3'd0, 1'b0, 1'b0); // reset state
        check_value("buzzer", 12'(buzzer), 12'h000);
        for (int r = 0; r < MAX_ROWS; r++) begin
            base = r * ROW_WORDS;
            op   = int'(rows[base]);
            if (op == 1)
                press_key(rows[base+1][15:0], int'(rows[base+2]), int'(rows[base+7]));
            else if (op == 2)
                wait_lockout();
            else
                break;
            check_outputs(rows[base+3][11:0], rows[base+4][2:0], rows[base+5][0],
                          rows[base+6][0]);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/code_lock_testdata.txt
// op keys hold display tries locked open tone, all hex; op 1 press, 2 lockout wait, 0 end
// tone 0 unchecked, 1 click, 2 pass, 3 fail
1 0040 02 ff2 0 0 0 1
1 0800 14 f24 0 0 0 0
1 0200 02 246 0 0 0 0
1 0080 02 246 0 0 0 1
1 0001 02 bcc 0 0 1 2
1 1000 02 fff 0 0 0 0
1 0040 02 ff2 0 0 0 0
1 0800 02 f24 0 0 0 0
1 0001 02 f24 0 0 0 0
1 0020 02 243 0 0 0 0
1 0001 02 fff 1 0 0 3
1 8000 02 ff7 1 0 0 0
1 4000 02 f78 1 0 0 0
1 2000 02 789 1 0 0 0
1 0001 02 fff 2 0 0 0
1 0080 02 ff1 2 0 0 0
1 0020 02 f13 2 0 0 0
1 0400 02 135 2 0 0 0
1 0001 02 fff 3 0 0 0
1 0800 02 ff4 3 0 0 0
1 0400 02 f45 3 0 0 0
1 0200 02 456 3 0 0 0
1 0001 02 000 0 1 0 0
1 0040 02 000 0 1 0 0
2 0000 00 fff 0 0 0 0
1 2000 02 ff9 0 0 0 0
1 2000 02 f99 0 0 0 0
1 2000 02 999 0 0 0 0
1 0001 02 fff 1 0 0 0
1 0100 02 fff 0 0 0 0
0 0000 00 000 0 0 0 0

//--- tb.f
rtl/code_lock_pkg.sv
rtl/key_decoder.sv
rtl/entry_controller.sv
rtl/lockout_timer.sv
rtl/tone_generator.sv
rtl/code_lock_top.sv
testbench/tb_code_lock.sv

//--- run_sim.sh
#!/bin/sh
# build the code lock testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_code_lock -Mdir "$OBJ" -f tb.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$OBJ/Vtb_code_lock" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
